// File: sd_phy_defines.svh
// sd phy constants
`ifndef SD_PHY_DEFINES_SVH
`define SD_PHY_DEFINES_SVH

// frame lengths on the CMD line
`define SD_CMD_BITS 48
`define SD_LONG_RESP_BITS 136

// host clocks to wait once CMD is seen high after power-up
`define SD_INIT_CLOCKS 60

// one data block and its word address into block RAM
`define SD_BLOCK_BYTES 512
`define SD_BLK_ADDR_W 7

// x^16 + x^12 + x^5 + 1
`define SD_CRC16_POLY 16'h1021

// x^7 + x^3 + 1
`define SD_CRC7_POLY 7'h09

`endif

// File: sd_phy_pkg.sv
// sd phy types and crc steps
`default_nettype none
`include "sd_phy_defines.svh"

package sd_phy_pkg;

   typedef enum logic [3:0] {
      RESP_R1  = 4'h1,
      RESP_R1B = 4'h2,
      RESP_R2  = 4'h3,
      RESP_R3  = 4'h4,
      RESP_R6  = 4'h6,
      RESP_R7  = 4'h7
   } resp_type_e;

   // command as it arrives, msb first
   typedef struct packed {
      logic        start;
      logic        dir;
      logic [5:0]  index;
      logic [31:0] arg;
      logic [6:0]  crc;
      logic        stop;
   } cmd_fields_t;

   typedef union packed {
      logic [`SD_CMD_BITS-1:0] raw;
      cmd_fields_t             f;
   } cmd_word_u;

   typedef struct packed {
      logic      valid;
      logic      crc_good;
      cmd_word_u word;
   } cmd_result_t;

   // short responses are left aligned in body
   typedef struct packed {
      logic                          act;
      resp_type_e                    rtype;
      logic [`SD_LONG_RESP_BITS-1:0] body;
   } resp_req_t;

   typedef struct packed {
      logic                      en;
      logic [`SD_BLK_ADDR_W-1:0] addr;
      logic [31:0]               data;
   } blk_wr_t;

   typedef struct packed {
      logic send;
      logic good;
   } crc_status_t;

   function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
      logic fb;
      fb = din ^ crc[6];
      return {crc[5:0], 1'b0} ^ (fb ? `SD_CRC7_POLY : 7'h00);
   endfunction

   function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic din);
      logic fb;
      fb = din ^ crc[15];
      return {crc[14:0], 1'b0} ^ (fb ? `SD_CRC16_POLY : 16'h0000);
   endfunction

endpackage

`default_nettype wire

// File: sd_cmd_rx.sv
// sd command receiver
`timescale 1ns/1ns
`default_nettype none
`include "sd_phy_defines.svh"

module sd_cmd_rx (
   input  wire                     sd_clk,
   input  wire                     reset_n,
   input  wire                     cmd_i,
   input  wire                     resp_busy_i,
   output sd_phy_pkg::cmd_result_t cmd_o
);

   // crc7 covers everything ahead of the crc field
   localparam int CRC_BITS = `SD_CMD_BITS - 8;

   typedef enum logic [2:0] {ST_PWR, ST_WAIT, ST_IDLE, ST_READ, ST_CHECK} state_e;

   state_e                state_q;
   logic [5:0]            cnt_q;
   logic                  cmd_last_q;
   logic [6:0]            crc_q;
   sd_phy_pkg::cmd_word_u shift_q;
   sd_phy_pkg::cmd_word_u word_nxt;

   // whole frame including the end bit on the line now
   always_comb begin
      word_nxt.raw = {shift_q.raw[`SD_CMD_BITS-2:0], cmd_i};
   end

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q    <= ST_PWR;
         cnt_q      <= '0;
         cmd_last_q <= 1'b1;
         crc_q      <= '0;
         shift_q    <= '0;
         cmd_o      <= '0;
      end else begin
         cmd_last_q  <= cmd_i;
         cmd_o.valid <= 1'b0;
         case (state_q)
            ST_PWR: begin
               cnt_q <= '0;
               if (cmd_i)
                  state_q <= ST_WAIT;
            end
            ST_WAIT: begin
               cnt_q <= cnt_q + 6'd1;
               if (cnt_q == 6'(`SD_INIT_CLOCKS - 1))
                  state_q <= ST_IDLE;
            end
            ST_IDLE: begin
               // falling edge, not while our own response owns the line
               if (!cmd_i && cmd_last_q && !resp_busy_i) begin
                  shift_q <= '0;
                  crc_q   <= sd_phy_pkg::crc7_next(7'd0, cmd_i);
                  cnt_q   <= 6'd1;
                  state_q <= ST_READ;
               end
            end
            ST_READ: begin
               shift_q.raw <= word_nxt.raw;
               cnt_q       <= cnt_q + 6'd1;
               if (cnt_q < 6'(CRC_BITS))
                  crc_q <= sd_phy_pkg::crc7_next(crc_q, cmd_i);
               if (cnt_q == 6'(`SD_CMD_BITS - 2))
                  state_q <= ST_CHECK;
            end
            ST_CHECK: begin
               // end bit sampled here
               cmd_o.valid    <= 1'b1;
               cmd_o.crc_good <= (crc_q == word_nxt.f.crc);
               cmd_o.word     <= word_nxt;
               state_q        <= ST_IDLE;
            end
            default: state_q <= ST_PWR;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: sd_resp_tx.sv
// sd response transmitter
`timescale 1ns/1ns
`default_nettype none
`include "sd_phy_defines.svh"

module sd_resp_tx (
   input  wire                   sd_clk,
   input  wire                   reset_n,
   input  wire sd_phy_pkg::resp_req_t req_i,
   output logic                  cmd_o,
   output logic                  cmd_oe_o,
   output logic                  resp_busy_o,
   output logic                  resp_done_o
);

   localparam int SHORT_LAST = `SD_CMD_BITS - 1;
   localparam int LONG_LAST = `SD_LONG_RESP_BITS - 1;
   // R2 crc skips the start, direction and reserved bits
   localparam int LONG_CRC_FROM = 8;

   typedef enum logic [1:0] {ST_IDLE, ST_PRE, ST_SEND, ST_END} state_e;

   state_e                 state_q;
   sd_phy_pkg::resp_type_e rtype_q;
   logic [LONG_LAST:0]     body_q;
   logic [6:0]             crc_q;
   logic [7:0]             cnt_q;
   logic                   is_r2;
   logic                   is_r3;
   logic [7:0]             last_bit;
   logic [7:0]             crc_from;
   logic [7:0]             crc_at;

   always_comb begin
      is_r2    = (rtype_q == sd_phy_pkg::RESP_R2);
      is_r3    = (rtype_q == sd_phy_pkg::RESP_R3);
      last_bit = is_r2 ? 8'(LONG_LAST) : 8'(SHORT_LAST);
      // crc7 and end bit take the last 8 positions
      crc_at   = last_bit - 8'd7;
      crc_from = is_r2 ? 8'(LONG_CRC_FROM) : 8'd0;
   end

   assign resp_busy_o = (state_q != ST_IDLE);

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q     <= ST_IDLE;
         rtype_q     <= sd_phy_pkg::RESP_R1;
         body_q      <= '0;
         crc_q       <= '0;
         cnt_q       <= '0;
         cmd_o       <= 1'b1;
         cmd_oe_o    <= 1'b0;
         resp_done_o <= 1'b0;
      end else begin
         resp_done_o <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (req_i.act) begin
                  body_q  <= req_i.body;
                  rtype_q <= req_i.rtype;
                  crc_q   <= '0;
                  cnt_q   <= '0;
                  state_q <= ST_PRE;
               end
            end
            ST_PRE: state_q <= ST_SEND;
            ST_SEND: begin
               cmd_oe_o <= 1'b1;
               body_q   <= {body_q[LONG_LAST-1:0], 1'b1};
               cnt_q    <= cnt_q + 8'd1;
               if (cnt_q < crc_at) begin
                  cmd_o <= body_q[LONG_LAST];
                  if (cnt_q >= crc_from)
                     crc_q <= sd_phy_pkg::crc7_next(crc_q, body_q[LONG_LAST]);
               end else if (cnt_q < last_bit) begin
                  // R3 carries all ones in place of a crc
                  cmd_o <= is_r3 | crc_q[6];
                  crc_q <= {crc_q[5:0], 1'b1};
               end else begin
                  cmd_o   <= 1'b1;
                  state_q <= ST_END;
               end
            end
            ST_END: begin
               cmd_oe_o    <= 1'b0;
               cmd_o       <= 1'b1;
               resp_done_o <= 1'b1;
               state_q     <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: sd_dat_rx.sv
// sd data block receiver
`timescale 1ns/1ns
`default_nettype none
`include "sd_phy_defines.svh"

module sd_dat_rx (
   input  wire                     sd_clk,
   input  wire                     reset_n,
   input  wire [3:0]               dat_i,
   input  wire                     data_in_act_i,
   input  wire                     data_in_stop_i,
   input  wire                     mode_4bit_i,
   input  wire                     token_oe_i,
   output sd_phy_pkg::blk_wr_t     wr_o,
   output sd_phy_pkg::crc_status_t status_o,
   output logic                    data_in_busy_o,
   output logic                    data_in_done_o,
   output logic                    data_in_crc_good_o
);

   localparam int BLK_BITS = `SD_BLOCK_BYTES * 8;
   localparam int BLK_NIBBLES = `SD_BLOCK_BYTES * 2;
   localparam int CNT_W = $clog2(BLK_BITS);
   localparam int CRC_LEN = 16;

   typedef enum logic [2:0] {ST_IDLE, ST_ARM, ST_DATA, ST_CRC, ST_DONE} state_e;

   state_e           state_q;
   logic             mode4_q;
   logic             act_last_q;
   logic             dat0_last_q;
   logic [CNT_W-1:0] cnt_q;
   logic [3:0][15:0] crc_q;
   logic [3:0][15:0] crc_nxt;
   logic [31:0]      word_nxt;
   logic             word_end;
   logic             data_end;
   logic             crc_ok;

   always_comb begin
      for (int l = 0; l < 4; l++)
         crc_nxt[l] = sd_phy_pkg::crc16_next(crc_q[l], dat_i[l]);
      // dat3 is the msb of each nibble
      word_nxt = mode4_q ? {wr_o.data[27:0], dat_i} : {wr_o.data[30:0], dat_i[0]};
      word_end = mode4_q ? (cnt_q[2:0] == 3'd7) : (cnt_q[4:0] == 5'd31);
      data_end = (cnt_q == (mode4_q ? CNT_W'(BLK_NIBBLES - 1) : CNT_W'(BLK_BITS - 1)));
      // running the received crc through the register leaves zero
      crc_ok = mode4_q ? (crc_q == '0) : (crc_q[0] == 16'd0);
   end

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q            <= ST_IDLE;
         mode4_q            <= 1'b0;
         act_last_q         <= 1'b0;
         dat0_last_q        <= 1'b1;
         cnt_q              <= '0;
         crc_q              <= '0;
         wr_o               <= '0;
         status_o           <= '0;
         data_in_busy_o     <= 1'b0;
         data_in_done_o     <= 1'b0;
         data_in_crc_good_o <= 1'b0;
      end else begin
         act_last_q    <= data_in_act_i;
         dat0_last_q   <= dat_i[0];
         wr_o.en       <= 1'b0;
         status_o.send <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (data_in_act_i && !act_last_q) begin
                  data_in_busy_o <= 1'b1;
                  data_in_done_o <= 1'b0;
                  mode4_q        <= mode_4bit_i;
                  state_q        <= ST_ARM;
               end
            end
            ST_ARM: begin
               // start bit, ignoring our own token on dat0
               if (!dat_i[0] && dat0_last_q && !token_oe_i) begin
                  crc_q     <= '0;
                  cnt_q     <= '0;
                  wr_o.addr <= '1;
                  state_q   <= ST_DATA;
               end
            end
            ST_DATA: begin
               wr_o.data <= word_nxt;
               crc_q     <= crc_nxt;
               cnt_q     <= cnt_q + 1'b1;
               if (word_end) begin
                  wr_o.en   <= 1'b1;
                  wr_o.addr <= wr_o.addr + 1'b1;
               end
               if (data_end) begin
                  cnt_q   <= '0;
                  state_q <= ST_CRC;
               end
            end
            ST_CRC: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q < CNT_W'(CRC_LEN)) begin
                  crc_q <= crc_nxt;
               end else begin
                  // end bit
                  data_in_done_o     <= 1'b1;
                  data_in_crc_good_o <= crc_ok;
                  status_o.send      <= 1'b1;
                  status_o.good      <= crc_ok;
                  state_q            <= ST_DONE;
               end
            end
            ST_DONE: begin
               // hold busy until the link lets go of act
               if (!data_in_act_i) begin
                  data_in_busy_o <= 1'b0;
                  state_q        <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
         if (data_in_stop_i && (state_q inside {ST_ARM, ST_DATA, ST_CRC})) begin
            data_in_done_o     <= 1'b1;
            data_in_crc_good_o <= 1'b0;
            status_o.send      <= 1'b0;
            state_q            <= ST_DONE;
         end
      end
   end

endmodule

`default_nettype wire

// File: sd_crc_token_tx.sv
// sd crc status token sender
`timescale 1ns/1ns
`default_nettype none

module sd_crc_token_tx (
   input  wire                     sd_clk,
   input  wire                     reset_n,
   input  wire sd_phy_pkg::crc_status_t status_i,
   input  wire                     data_in_act_i,
   output logic                    dat0_o,
   output logic                    dat0_oe_o
);

   typedef enum logic [2:0] {ST_IDLE, ST_TOKEN, ST_BUSY, ST_HIGH, ST_REL} state_e;

   state_e     state_q;
   logic [4:0] tok_q;
   logic [2:0] cnt_q;

   always_ff @(posedge sd_clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q   <= ST_IDLE;
         tok_q     <= '0;
         cnt_q     <= '0;
         dat0_o    <= 1'b1;
         dat0_oe_o <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (status_i.send) begin
                  // start, status, end bit
                  tok_q   <= {1'b0, (status_i.good ? 3'b010 : 3'b101), 1'b1};
                  cnt_q   <= '0;
                  state_q <= ST_TOKEN;
               end
            end
            ST_TOKEN: begin
               dat0_oe_o <= 1'b1;
               dat0_o    <= tok_q[4];
               tok_q     <= {tok_q[3:0], 1'b1};
               cnt_q     <= cnt_q + 3'd1;
               if (cnt_q == 3'd4)
                  state_q <= ST_BUSY;
            end
            ST_BUSY: begin
               // card busy while the link still holds act
               dat0_o <= 1'b0;
               if (!data_in_act_i)
                  state_q <= ST_HIGH;
            end
            ST_HIGH: begin
               dat0_o  <= 1'b1;
               state_q <= ST_REL;
            end
            ST_REL: begin
               dat0_oe_o <= 1'b0;
               state_q   <= ST_IDLE;
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: sd_phy.sv
// sd mode physical layer
`timescale 1ns/1ns
`default_nettype none

module sd_phy (
   input  wire                       sd_clk,
   input  wire                       reset_n,
   input  wire                       cmd_i,
   input  wire [3:0]                 dat_i,
   input  wire                       data_in_act_i,
   input  wire                       data_in_stop_i,
   input  wire                       mode_4bit_i,
   input  wire sd_phy_pkg::resp_req_t resp_req_i,
   output logic                      cmd_o,
   output logic                      cmd_oe_o,
   output logic [3:0]                dat_o,
   output logic [3:0]                dat_oe_o,
   output sd_phy_pkg::cmd_result_t   cmd_result_o,
   output logic                      resp_done_o,
   output sd_phy_pkg::blk_wr_t       wr_o,
   output logic                      data_in_busy_o,
   output logic                      data_in_done_o,
   output logic                      data_in_crc_good_o
);

   logic                    resp_busy;
   logic                    dat0;
   logic                    dat0_oe;
   sd_phy_pkg::crc_status_t blk_status;

   // only dat0 is ever driven, for the token and busy
   assign dat_o    = {3'b000, dat0};
   assign dat_oe_o = {3'b000, dat0_oe};

   sd_cmd_rx sd_cmd_rx_inst (
      .sd_clk      (sd_clk),
      .reset_n     (reset_n),
      .cmd_i       (cmd_i),
      .resp_busy_i (resp_busy),
      .cmd_o       (cmd_result_o)
   );

   sd_resp_tx sd_resp_tx_inst (
      .sd_clk      (sd_clk),
      .reset_n     (reset_n),
      .req_i       (resp_req_i),
      .cmd_o       (cmd_o),
      .cmd_oe_o    (cmd_oe_o),
      .resp_busy_o (resp_busy),
      .resp_done_o (resp_done_o)
   );

   sd_dat_rx sd_dat_rx_inst (
      .sd_clk             (sd_clk),
      .reset_n            (reset_n),
      .dat_i              (dat_i),
      .data_in_act_i      (data_in_act_i),
      .data_in_stop_i     (data_in_stop_i),
      .mode_4bit_i        (mode_4bit_i),
      .token_oe_i         (dat0_oe),
      .wr_o               (wr_o),
      .status_o           (blk_status),
      .data_in_busy_o     (data_in_busy_o),
      .data_in_done_o     (data_in_done_o),
      .data_in_crc_good_o (data_in_crc_good_o)
   );

   sd_crc_token_tx sd_crc_token_tx_inst (
      .sd_clk        (sd_clk),
      .reset_n       (reset_n),
      .status_i      (blk_status),
      .data_in_act_i (data_in_act_i),
      .dat0_o        (dat0),
      .dat0_oe_o     (dat0_oe)
   );

endmodule

`default_nettype wire

// File: tb_sd_phy.sv
// sd phy testbench
`timescale 1ns/1ns
`default_nettype none
`include "sd_phy_defines.svh"

module tb_sd_phy;

   localparam int CLK_PERIOD = 100;
   localparam int DRIVE_DELAY = 10;
   localparam int CYCLES_PER_LINE = 6000;
   localparam int WAIT_LIMIT = 200;
   localparam int WORDS = `SD_BLOCK_BYTES / 4;

   logic                    sd_clk;
   logic                    reset_n;
   logic                    cmd_i;
   logic [3:0]              dat_i;
   logic                    data_in_act_i;
   logic                    data_in_stop_i;
   logic                    mode_4bit_i;
   sd_phy_pkg::resp_req_t   resp_req;
   logic                    cmd_o;
   logic                    cmd_oe_o;
   logic [3:0]              dat_o;
   logic [3:0]              dat_oe_o;
   sd_phy_pkg::cmd_result_t cmd_result;
   logic                    resp_done_o;
   sd_phy_pkg::blk_wr_t     wr;
   logic                    data_in_busy_o;
   logic                    data_in_done_o;
   logic                    data_in_crc_good_o;

   // parsed stimulus records
   byte          rec_kind[$];
   int           rec_a[$];
   logic [135:0] rec_b[$];
   int           rec_c[$];
   bit           loaded;

   logic [31:0] block_words [0:WORDS-1];
   logic [3:0]  block_sym [0:`SD_BLOCK_BYTES*8-1];
   int          writes_seen;

   sd_phy sd_phy_inst (
      .sd_clk             (sd_clk),
      .reset_n            (reset_n),
      .cmd_i              (cmd_i),
      .dat_i              (dat_i),
      .data_in_act_i      (data_in_act_i),
      .data_in_stop_i     (data_in_stop_i),
      .mode_4bit_i        (mode_4bit_i),
      .resp_req_i         (resp_req),
      .cmd_o              (cmd_o),
      .cmd_oe_o           (cmd_oe_o),
      .dat_o              (dat_o),
      .dat_oe_o           (dat_oe_o),
      .cmd_result_o       (cmd_result),
      .resp_done_o        (resp_done_o),
      .wr_o               (wr),
      .data_in_busy_o     (data_in_busy_o),
      .data_in_done_o     (data_in_done_o),
      .data_in_crc_good_o (data_in_crc_good_o)
   );

   initial begin
      sd_clk = 1'b0;
      forever #(CLK_PERIOD/2) sd_clk = ~sd_clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [135:0] got, input logic [135:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
         fail_run("value mismatch");
      end
   endtask

   // inputs change and outputs are read here, well clear of the edge
   task automatic tick();
      @(posedge sd_clk);
      #(DRIVE_DELAY);
   endtask

   function automatic logic [15:0] crc16_lane(input int lane, input int count);
      logic [15:0] crc;
      logic        fb;
      crc = 16'h0000;
      for (int i = 0; i < count; i++) begin
         fb  = block_sym[i][lane] ^ crc[15];
         crc = {crc[14:0], 1'b0};
         if (fb)
            crc = crc ^ `SD_CRC16_POLY;
      end
      return crc;
   endfunction

   task automatic load_stimulus();
      int           fd;
      int           code;
      byte          kind;
      string        rest;
      int           a;
      logic [135:0] b;
      int           c;
      fd = $fopen("sd_phy_stim.txt", "r");
      if (fd == 0)
         fail_run("could not open the stimulus file sd_phy_stim.txt");
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", kind);
         if (code != 1)
            break;
         a = 0;
         if (kind == "#") begin
            code = $fgets(rest, fd);
            continue;
         end else if (kind == "C") begin
            code = $fscanf(fd, "%h %h", b, c);
         end else if (kind == "R" || kind == "D") begin
            code = $fscanf(fd, "%d %h %h", a, b, c);
         end else begin
            fail_run("the stimulus file holds a line of unknown kind");
         end
         rec_kind.push_back(kind);
         rec_a.push_back(a);
         rec_b.push_back(b);
         rec_c.push_back(c);
      end
      $fclose(fd);
   endtask

   task automatic watch_write();
      if (wr.en) begin
         if (writes_seen >= WORDS)
            fail_run("more block RAM writes than words in a block");
         check("wr_o.addr", wr.addr, writes_seen);
         check("wr_o.data", wr.data, block_words[writes_seen]);
         writes_seen++;
      end
   endtask

   task automatic run_command(input logic [47:0] frame, input logic good);
      repeat (4) tick();
      for (int k = 0; k < `SD_CMD_BITS; k++) begin
         tick();
         cmd_i = frame[`SD_CMD_BITS-1-k];
         check("cmd_result_o.valid", cmd_result.valid, 1'b0);
      end
      // end bit was sampled on the edge just passed
      tick();
      cmd_i = 1'b1;
      check("cmd_result_o.valid", cmd_result.valid, 1'b1);
      check("cmd_result_o.crc_good", cmd_result.crc_good, good);
      check("cmd_result_o.word", cmd_result.word.raw, frame);
      tick();
      check("cmd_result_o.valid", cmd_result.valid, 1'b0);
   endtask

   task automatic run_response(input int rtype, input logic [135:0] body_in, input logic [6:0] crc);
      logic [135:0] body;
      logic [135:0] got;
      logic [135:0] exp;
      int           nbits;
      int           n;
      nbits = (rtype == sd_phy_pkg::RESP_R2) ? `SD_LONG_RESP_BITS : `SD_CMD_BITS;
      body  = (nbits == `SD_LONG_RESP_BITS) ? body_in : (body_in << 88);
      got   = '0;
      exp   = '0;
      // body, then crc7, then end bit
      for (int k = 0; k < nbits; k++) begin
         if (k < nbits - 8)
            exp[135-k] = body[135-k];
         else if (k < nbits - 1)
            exp[135-k] = crc[6-(k-(nbits-8))];
         else
            exp[135-k] = 1'b1;
      end
      tick();
      resp_req.act   = 1'b1;
      resp_req.rtype = sd_phy_pkg::resp_type_e'(rtype[3:0]);
      resp_req.body  = body;
      tick();
      resp_req.act = 1'b0;
      n = 1;
      while (cmd_oe_o !== 1'b1) begin
         tick();
         n++;
         if (n > WAIT_LIMIT)
            fail_run("cmd_oe_o never rose for the response");
      end
      check("cmd_oe_o rise delay", n, 3);
      for (int k = 0; k < nbits; k++) begin
         check("cmd_oe_o", cmd_oe_o, 1'b1);
         check("resp_done_o", resp_done_o, 1'b0);
         got[135-k] = cmd_o;
         tick();
      end
      check("cmd_oe_o", cmd_oe_o, 1'b0);
      check("resp_done_o", resp_done_o, 1'b1);
      check("cmd_o frame", got, exp);
      tick();
      check("resp_done_o", resp_done_o, 1'b0);
   endtask

   task automatic run_block(input int mode, input logic corrupt, input logic stop);
      logic        lanes4;
      logic        good;
      logic [4:0]  tok;
      logic [15:0] crc [0:3];
      logic [3:0]  sym;
      int          nsym;
      int          total;
      int          stop_at;
      int          bad_lane;
      int          j;
      int          n;
      lanes4 = (mode == 4);
      good   = !corrupt;
      nsym   = lanes4 ? `SD_BLOCK_BYTES * 2 : `SD_BLOCK_BYTES * 8;
      total  = nsym + 17;
      // stop lands on a word boundary
      stop_at = nsym / 2;
      writes_seen = 0;
      for (int w = 0; w < WORDS; w++) begin
         block_words[w] = $urandom();
         for (int b = 0; b < (lanes4 ? 8 : 32); b++) begin
            if (lanes4)
               block_sym[w*8+b] = block_words[w][31-4*b -: 4];
            else
               block_sym[w*32+b] = {3'b111, block_words[w][31-b]};
         end
      end
      for (int l = 0; l < 4; l++)
         crc[l] = crc16_lane(l, nsym);
      // in 4-bit mode the bad crc sits on a line other than dat0
      bad_lane = lanes4 ? 3 : 0;
      if (corrupt)
         crc[bad_lane][0] = ~crc[bad_lane][0];

      tick();
      mode_4bit_i   = lanes4;
      data_in_act_i = 1'b1;
      dat_i         = 4'hF;
      tick();
      check("data_in_busy_o", data_in_busy_o, 1'b1);
      check("data_in_done_o", data_in_done_o, 1'b0);
      repeat (2) tick();
      dat_i = 4'h0;
      for (int i = 0; i < total; i++) begin
         if (stop && i == stop_at)
            break;
         j = i - nsym;
         if (i < nsym)
            sym = block_sym[i];
         else if (i < nsym + 16)
            sym = lanes4 ? {crc[3][15-j], crc[2][15-j], crc[1][15-j], crc[0][15-j]}
                         : {3'b111, crc[0][15-j]};
         else
            sym = 4'hF;
         tick();
         dat_i = sym;
         watch_write();
      end

      if (stop) begin
         tick();
         data_in_stop_i = 1'b1;
         watch_write();
         tick();
         data_in_stop_i = 1'b0;
         dat_i          = 4'hF;
         watch_write();
         check("data_in_done_o", data_in_done_o, 1'b1);
         check("data_in_crc_good_o", data_in_crc_good_o, 1'b0);
         check("writes before stop", writes_seen, stop_at / (lanes4 ? 8 : 32));
         repeat (20) begin
            tick();
            check("dat_oe_o", dat_oe_o, 4'b0000);
            check("wr_o.en", wr.en, 1'b0);
         end
      end else begin
         n = 0;
         while (data_in_done_o !== 1'b1) begin
            tick();
            watch_write();
            n++;
            if (n > WAIT_LIMIT)
               fail_run("data_in_done_o never rose after the block");
         end
         check("block writes", writes_seen, WORDS);
         check("data_in_crc_good_o", data_in_crc_good_o, good);
         n = 0;
         while (dat_oe_o[0] !== 1'b1) begin
            tick();
            n++;
            if (n > WAIT_LIMIT)
               fail_run("no CRC status token appeared on DAT0");
         end
         // start 0, status, end 1
         tok = good ? 5'b00101 : 5'b01011;
         for (int k = 0; k < 5; k++) begin
            check("dat_oe_o", dat_oe_o, 4'b0001);
            check("dat_o token bit", dat_o[0], tok[4-k]);
            tick();
         end
         // busy low on dat0 while act is held
         repeat (8) begin
            check("dat_oe_o", dat_oe_o, 4'b0001);
            check("dat_o busy", dat_o[0], 1'b0);
            check("data_in_busy_o", data_in_busy_o, 1'b1);
            tick();
         end
      end

      data_in_act_i = 1'b0;
      n = 0;
      while (data_in_busy_o !== 1'b0) begin
         tick();
         n++;
         if (n > WAIT_LIMIT)
            fail_run("data_in_busy_o stayed high after act was dropped");
      end
      if (!stop) begin
         n = 0;
         while (dat_o[0] !== 1'b1) begin
            check("dat_oe_o", dat_oe_o, 4'b0001);
            tick();
            n++;
            if (n > WAIT_LIMIT)
               fail_run("dat0 never went high to end the busy signal");
         end
         check("dat_oe_o", dat_oe_o, 4'b0001);
         tick();
         check("dat_oe_o", dat_oe_o, 4'b0000);
      end
      check("data_in_done_o", data_in_done_o, 1'b1);
   endtask

   initial begin
      wait (loaded);
      repeat (200 + rec_kind.size() * CYCLES_PER_LINE) @(posedge sd_clk);
      fail_run("timeout, the tests did not finish within their cycle budget");
   end

   initial begin
      logic [135:0] b;
      void'($urandom(32'ha0f5fd17));
      reset_n        = 1'b0;
      cmd_i          = 1'b1;
      dat_i          = 4'hF;
      data_in_act_i  = 1'b0;
      data_in_stop_i = 1'b0;
      mode_4bit_i    = 1'b0;
      resp_req       = '0;
      writes_seen    = 0;
      load_stimulus();
      loaded = 1'b1;

      repeat (4) @(posedge sd_clk);
      #(DRIVE_DELAY);
      check("cmd_oe_o", cmd_oe_o, 1'b0);
      check("dat_oe_o", dat_oe_o, 4'b0000);
      check("resp_done_o", resp_done_o, 1'b0);
      check("cmd_result_o.valid", cmd_result.valid, 1'b0);
      check("wr_o.en", wr.en, 1'b0);
      check("data_in_busy_o", data_in_busy_o, 1'b0);
      check("data_in_done_o", data_in_done_o, 1'b0);
      repeat (4) @(posedge sd_clk);
      #(DRIVE_DELAY);
      reset_n = 1'b1;
      // cmd held high through the power-up wait
      repeat (80) tick();

      for (int r = 0; r < rec_kind.size(); r++) begin
         b = rec_b[r];
         case (rec_kind[r])
            "C": run_command(b[47:0], rec_c[r] != 0);
            "R": run_response(rec_a[r], b, rec_c[r][6:0]);
            default: run_block(rec_a[r], b != 0, rec_c[r] != 0);
         endcase
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
sd_phy_pkg.sv
sd_cmd_rx.sv
sd_resp_tx.sv
sd_dat_rx.sv
sd_crc_token_tx.sv
sd_phy.sv
tb_sd_phy.sv

// File: Bender.yml
package:
  name: sd_phy

export_include_dirs:
  - .

sources:
  - sd_phy_pkg.sv
  - sd_cmd_rx.sv
  - sd_resp_tx.sv
  - sd_dat_rx.sv
  - sd_crc_token_tx.sv
  - sd_phy.sv
  - target: simulation
    files:
      - tb_sd_phy.sv

// File: sd_phy_stim.txt
# C <48-bit command frame> <expected crc_good>
# R <response type code> <body, 48 or 136 bits> <expected crc7>
# D <bus width 1 or 4> <corrupt crc> <stop mid-block>
C 400000000095 1
C 48000001AA87 1
C 510000000055 1
C 770000000065 1
C 400000000097 0
C 51000000005D 0
R 1 110000090000 33
R 7 08000001AA00 09
R 4 3F80FF800000 7F
R 3 3F0000000000000000000048000001AA00 43
D 1 0 0
D 4 0 0
D 1 1 0
D 4 1 0
D 4 0 1
D 1 0 1
D 4 0 0
